//--- dram_stream_cl_defs.svh
`ifndef DRAM_STREAM_CL_DEFS_SVH
`define DRAM_STREAM_CL_DEFS_SVH

// ------------------------------------------------
// Channel geometry
// ------------------------------------------------

// Status layout packs one field per channel, so this stays at four
`define DDR_CHANNELS 4

`define DDR_ADDR_W 64
`define DDR_DATA_W 512
`define DDR_STRB_W (`DDR_DATA_W / 8)
`define DDR_ID_W   16
`define DDR_LEN_W  8

// Engine traffic always moves 64 bytes per beat
`define ENG_AXSIZE 3'b110

// ------------------------------------------------
// Host visible constants
// ------------------------------------------------
`define CL_VERSION 32'hee_ee_ee_00
`define CL_ID0     32'h5ca1_1d0e
`define CL_ID1     32'h0000_0a11
`define STATUS_TAG 20'ha111_1

`endif

//--- rtl/dram_stream_pkg.sv
`include "dram_stream_cl_defs.svh"

package dram_stream_pkg;

  // ------------------------------------------------
  // Requester to memory
  // ------------------------------------------------
  typedef struct packed {
    // Write address
    logic [`DDR_ID_W-1:0]   awid;
    logic [`DDR_ADDR_W-1:0] awaddr;
    logic [`DDR_LEN_W-1:0]  awlen;
    logic [2:0]             awsize;
    logic                   awvalid;
    // Write data
    logic [`DDR_DATA_W-1:0] wdata;
    logic [`DDR_STRB_W-1:0] wstrb;
    logic                   wlast;
    logic                   wvalid;
    // Write response
    logic                   bready;
    // Read address
    logic [`DDR_ID_W-1:0]   arid;
    logic [`DDR_ADDR_W-1:0] araddr;
    logic [`DDR_LEN_W-1:0]  arlen;
    logic [2:0]             arsize;
    logic                   arvalid;
    // Read data
    logic                   rready;
  } ddr_req_t;

  // ------------------------------------------------
  // Memory back to requester
  // ------------------------------------------------
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   arready;
    logic [`DDR_ID_W-1:0]   bid;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic [`DDR_ID_W-1:0]   rid;
    logic [`DDR_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rlast;
    logic                   rvalid;
  } ddr_rsp_t;

  // One scrubber as seen from the control block
  typedef struct packed {
    logic [2:0]             state;
    logic                   done;
    logic [`DDR_ADDR_W-1:0] addr;
  } scrb_stat_t;

  typedef enum logic [1:0] {
    HOST_OWNS,
    ENGINE_RESET,
    ENGINE_OWNS
  } handover_state_e;

endpackage

//--- rtl/host_ctl_regs.sv
`timescale 1ns/1ps
`include "dram_stream_cl_defs.svh"

module host_ctl_regs (
  input  logic                        clk,
  input  logic                        sync_rst_n,
  input  logic [31:0]                 ctl0,
  input  logic [`DDR_CHANNELS-1:0]    ddr_ready,
  input  dram_stream_pkg::scrb_stat_t scrb_stat [`DDR_CHANNELS],
  input  logic                        flr_assert,
  output logic [`DDR_CHANNELS-1:0]    scrb_enable,
  output logic [31:0]                 status0,
  output logic [31:0]                 status1,
  output logic [31:0]                 id0,
  output logic [31:0]                 id1,
  output logic                        flr_done
);

  logic [31:0]               ctl0_q;
  logic [`DDR_CHANNELS-1:0]  ddr_ready_q;
  logic                      flr_assert_q;
  logic                      dbg_en;
  logic [2:0]                dbg_sel;
  logic [1:0]                dbg_chan;
  logic [`DDR_CHANNELS-1:0]  scrb_done;
  logic [4*`DDR_CHANNELS-1:0] scrb_state_f;
  logic [`DDR_ADDR_W-1:0]    dbg_addr;
  logic [31:0]               status0_nxt;

  // ------------------------------------------------
  // Control word capture
  // ------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      ctl0_q       <= '0;
      ddr_ready_q  <= '0;
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
    end else begin
      ctl0_q       <= ctl0;
      ddr_ready_q  <= ddr_ready;
      flr_assert_q <= flr_assert;
      // A held request toggles the done flag
      flr_done     <= flr_assert_q && !flr_done;
    end
  end

  // Low bits enable one scrubber each
  assign scrb_enable = ctl0_q[`DDR_CHANNELS-1:0];
  assign dbg_en      = ctl0_q[31];
  assign dbg_sel     = ctl0_q[30:28];

  // Selects above the last channel fall back to channel 0
  assign dbg_chan = (dbg_sel >= 3'd1 && dbg_sel <= 3'd3) ? dbg_sel[1:0] : 2'd0;
  assign dbg_addr = scrb_stat[dbg_chan].addr;

  // ------------------------------------------------
  // Status composition
  // ------------------------------------------------
  always_comb begin
    for (int i = 0; i < `DDR_CHANNELS; i++) begin
      scrb_done[i]           = scrb_stat[i].done;
      scrb_state_f[4*i +: 4] = {1'b0, scrb_stat[i].state};
    end
    if (dbg_en) begin
      status0_nxt = {scrb_state_f, 4'h0, 4'hf, scrb_done, ddr_ready_q};
    end else begin
      status0_nxt = {`STATUS_TAG, 4'hf, scrb_done, ddr_ready_q};
    end
  end

  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      status0 <= '0;
      id0     <= '0;
      id1     <= '0;
    end else begin
      status0 <= status0_nxt;
      id0     <= dbg_en ? dbg_addr[31:0] : `CL_ID0;
      id1     <= dbg_en ? dbg_addr[63:32] : `CL_ID1;
    end
  end

  assign status1 = `CL_VERSION;

  // Done never stays high for two cycles, even with the request held
  a_flr_single: assert property (@(posedge clk) disable iff (!sync_rst_n)
    flr_done |=> !flr_done);

  // Done answers a request seen two cycles earlier
  a_flr_cause: assert property (@(posedge clk) disable iff (!sync_rst_n)
    $rose(flr_done) |-> $past(flr_assert, 2));

endmodule

//--- rtl/stream_handover.sv
`timescale 1ns/1ps

module stream_handover (
  input  logic clk,
  input  logic sync_rst_n,
  input  logic stream_start,
  input  logic engine_finished,
  output logic engine_reset,
  output logic stream_owns,
  output logic stream_done
);

  dram_stream_pkg::handover_state_e state;
  dram_stream_pkg::handover_state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      dram_stream_pkg::HOST_OWNS: begin
        if (stream_start) state_nxt = dram_stream_pkg::ENGINE_RESET;
      end
      // Reset lasts a single cycle before the grant
      dram_stream_pkg::ENGINE_RESET: state_nxt = dram_stream_pkg::ENGINE_OWNS;
      dram_stream_pkg::ENGINE_OWNS: begin
        if (engine_finished) state_nxt = dram_stream_pkg::HOST_OWNS;
      end
      default: state_nxt = dram_stream_pkg::HOST_OWNS;
    endcase
  end

  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      state <= dram_stream_pkg::HOST_OWNS;
    end else begin
      state <= state_nxt;
    end
  end

  assign engine_reset = (state == dram_stream_pkg::ENGINE_RESET);
  assign stream_owns  = (state == dram_stream_pkg::ENGINE_OWNS);
  assign stream_done  = stream_owns && engine_finished;

  // One reset cycle, then the channels belong to the engine
  a_reset_then_grant: assert property (@(posedge clk) disable iff (!sync_rst_n)
    engine_reset |=> (stream_owns && !engine_reset));

  a_grant_after_reset: assert property (@(posedge clk) disable iff (!sync_rst_n)
    $rose(stream_owns) |-> $past(engine_reset));

endmodule

//--- rtl/ddr_chan_mux.sv
`timescale 1ns/1ps
`include "dram_stream_cl_defs.svh"

module ddr_chan_mux (
  input  logic                      stream_owns,
  input  dram_stream_pkg::ddr_req_t host_req,
  input  dram_stream_pkg::ddr_req_t eng_req,
  input  dram_stream_pkg::ddr_rsp_t mem_rsp,
  output dram_stream_pkg::ddr_rsp_t host_rsp,
  output dram_stream_pkg::ddr_rsp_t eng_rsp,
  output dram_stream_pkg::ddr_req_t mem_req
);

  // Side that does not own the channel sees no handshakes
  function automatic dram_stream_pkg::ddr_rsp_t clear_hs(input dram_stream_pkg::ddr_rsp_t rsp);
    dram_stream_pkg::ddr_rsp_t r;
    r         = rsp;
    r.awready = 1'b0;
    r.wready  = 1'b0;
    r.arready = 1'b0;
    r.bvalid  = 1'b0;
    r.rvalid  = 1'b0;
    return r;
  endfunction

  // ------------------------------------------------
  // Request path toward memory
  // ------------------------------------------------
  always_comb begin
    mem_req = stream_owns ? eng_req : host_req;
    if (stream_owns) begin
      // Engine beats are always full width
      mem_req.awsize = `ENG_AXSIZE;
      mem_req.arsize = `ENG_AXSIZE;
      mem_req.wstrb  = '1;
      mem_req.arid   = '0;
      // Engine never stalls write responses
      mem_req.bready = 1'b1;
    end
  end

  // ------------------------------------------------
  // Response path back to both requesters
  // ------------------------------------------------
  always_comb begin
    if (stream_owns) begin
      host_rsp       = clear_hs(mem_rsp);
      host_rsp.rresp = '0;
      eng_rsp        = mem_rsp;
    end else begin
      host_rsp = mem_rsp;
      eng_rsp  = clear_hs(mem_rsp);
    end
  end

  always_comb begin
    if (stream_owns) begin
      a_host_quiet: assert final (!(host_rsp.awready || host_rsp.wready ||
                                    host_rsp.arready || host_rsp.bvalid ||
                                    host_rsp.rvalid))
        else $error("host sees a handshake while the engine owns the channel");
    end else begin
      a_eng_quiet: assert final (!(eng_rsp.awready || eng_rsp.wready ||
                                   eng_rsp.arready || eng_rsp.bvalid ||
                                   eng_rsp.rvalid))
        else $error("engine sees a handshake while the host owns the channel");
    end
  end

endmodule

//--- rtl/dram_stream_cl.sv
`timescale 1ns/1ps
`include "dram_stream_cl_defs.svh"

module dram_stream_cl (
  input  logic                        clk,
  input  logic                        sync_rst_n,

  // Host control
  input  logic [31:0]                 ctl0,
  input  logic [`DDR_CHANNELS-1:0]    ddr_ready,
  input  dram_stream_pkg::scrb_stat_t scrb_stat [`DDR_CHANNELS],
  input  logic                        flr_assert,
  input  logic                        stream_start,
  input  logic                        engine_finished,

  // Channel traffic
  input  dram_stream_pkg::ddr_req_t   host_req [`DDR_CHANNELS],
  input  dram_stream_pkg::ddr_req_t   eng_req  [`DDR_CHANNELS],
  input  dram_stream_pkg::ddr_rsp_t   mem_rsp  [`DDR_CHANNELS],

  output logic [`DDR_CHANNELS-1:0]    scrb_enable,
  output logic [31:0]                 status0,
  output logic [31:0]                 status1,
  output logic [31:0]                 id0,
  output logic [31:0]                 id1,
  output logic                        flr_done,
  output logic                        engine_reset,
  output logic                        stream_done,
  output dram_stream_pkg::ddr_rsp_t   host_rsp [`DDR_CHANNELS],
  output dram_stream_pkg::ddr_rsp_t   eng_rsp  [`DDR_CHANNELS],
  output dram_stream_pkg::ddr_req_t   mem_req  [`DDR_CHANNELS]
);

  // Ownership is shared by every channel
  logic stream_owns;

  // ------------------------------------------------
  // Control and status
  // ------------------------------------------------
  host_ctl_regs u_host_ctl_regs (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .ctl0        (ctl0),
    .ddr_ready   (ddr_ready),
    .scrb_stat   (scrb_stat),
    .flr_assert  (flr_assert),
    .scrb_enable (scrb_enable),
    .status0     (status0),
    .status1     (status1),
    .id0         (id0),
    .id1         (id1),
    .flr_done    (flr_done)
  );

  stream_handover u_stream_handover (
    .clk             (clk),
    .sync_rst_n      (sync_rst_n),
    .stream_start    (stream_start),
    .engine_finished (engine_finished),
    .engine_reset    (engine_reset),
    .stream_owns     (stream_owns),
    .stream_done     (stream_done)
  );

  // ------------------------------------------------
  // Per channel ownership
  // ------------------------------------------------
  for (genvar ch = 0; ch < `DDR_CHANNELS; ch++) begin : g_chan
    ddr_chan_mux u_ddr_chan_mux (
      .stream_owns (stream_owns),
      .host_req    (host_req[ch]),
      .eng_req     (eng_req[ch]),
      .mem_rsp     (mem_rsp[ch]),
      .host_rsp    (host_rsp[ch]),
      .eng_rsp     (eng_rsp[ch]),
      .mem_req     (mem_req[ch])
    );
  end

endmodule

//--- sim/dram_stream_cl_checker.sv
`timescale 1ns/1ps
`include "dram_stream_cl_defs.svh"

module dram_stream_cl_checker (
  input logic                      clk,
  input logic                      sync_rst_n,
  input logic                      flr_assert,
  input logic                      stream_start,
  input logic                      engine_finished,
  input dram_stream_pkg::ddr_req_t host_req [`DDR_CHANNELS],
  input dram_stream_pkg::ddr_req_t eng_req  [`DDR_CHANNELS],
  input dram_stream_pkg::ddr_rsp_t mem_rsp  [`DDR_CHANNELS],
  input logic [`DDR_CHANNELS-1:0]  scrb_enable,
  input logic [31:0]               status0,
  input logic [31:0]               status1,
  input logic [31:0]               id0,
  input logic [31:0]               id1,
  input logic                      flr_done,
  input logic                      engine_reset,
  input logic                      stream_done,
  input dram_stream_pkg::ddr_rsp_t host_rsp [`DDR_CHANNELS],
  input dram_stream_pkg::ddr_rsp_t eng_rsp  [`DDR_CHANNELS],
  input dram_stream_pkg::ddr_req_t mem_req  [`DDR_CHANNELS]
);

  int    pass_count = 0;
  int    fail_count = 0;
  int    total_errs = 0;
  int    test_errs  = 0;
  string test_name  = "startup";

  // Reference state
  logic rst_m;
  logic owns_m;
  logic flr_q;
  logic flr_m;
  dram_stream_pkg::ddr_req_t exp_req;
  dram_stream_pkg::ddr_rsp_t exp_host;
  dram_stream_pkg::ddr_rsp_t exp_eng;

  task automatic report_mismatch(input string what, input string exp_s, input string act_s);
    $display("[FAIL] %s: %s expected %s, actual %s", test_name, what, exp_s, act_s);
    test_errs++;
    total_errs++;
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("[TEST] %s passed", test_name);
      pass_count++;
    end else begin
      $display("[TEST] %s failed with %0d mismatches", test_name, test_errs);
      fail_count++;
    end
  endtask

  task automatic expect_regs(input logic [3:0] en, input logic [31:0] st0,
                             input logic [31:0] i0, input logic [31:0] i1);
    check_val("scrb_enable", {28'b0, en}, {28'b0, scrb_enable});
    check_val("status0", st0, status0);
    check_val("status1", `CL_VERSION, status1);
    check_val("id0", i0, id0);
    check_val("id1", i1, id1);
  endtask

  task automatic expect_idle();
    check_val("flr_done", 32'd0, {31'b0, flr_done});
    check_val("scrb_enable", 32'd0, {28'b0, scrb_enable});
    check_val("engine_reset", 32'd0, {31'b0, engine_reset});
    check_val("stream_done", 32'd0, {31'b0, stream_done});
    check_val("status0", 32'd0, status0);
    check_val("id0", 32'd0, id0);
    check_val("id1", 32'd0, id1);
  endtask

  // Engine requests reach memory with fixed size, strobes, read ID and bready
  function automatic dram_stream_pkg::ddr_req_t engine_view(input dram_stream_pkg::ddr_req_t e);
    dram_stream_pkg::ddr_req_t r;
    r        = e;
    r.awsize = `ENG_AXSIZE;
    r.arsize = `ENG_AXSIZE;
    r.wstrb  = '1;
    r.arid   = '0;
    r.bready = 1'b1;
    return r;
  endfunction

  function automatic dram_stream_pkg::ddr_rsp_t quiet(input dram_stream_pkg::ddr_rsp_t m);
    dram_stream_pkg::ddr_rsp_t r;
    r         = m;
    r.awready = 1'b0;
    r.wready  = 1'b0;
    r.arready = 1'b0;
    r.bvalid  = 1'b0;
    r.rvalid  = 1'b0;
    return r;
  endfunction

  // --------------------------------------------------
  // Timing model of the handover and FLR response
  // --------------------------------------------------
  always @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      rst_m  <= 1'b0;
      owns_m <= 1'b0;
      flr_q  <= 1'b0;
      flr_m  <= 1'b0;
    end else begin
      flr_q  <= flr_assert;
      flr_m  <= flr_q && !flr_m;
      rst_m  <= stream_start && !rst_m && !owns_m;
      owns_m <= rst_m || (owns_m && !engine_finished);
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (sync_rst_n) begin
      check_val("engine_reset", {31'b0, rst_m}, {31'b0, engine_reset});
      check_val("stream_done", {31'b0, (owns_m && engine_finished)}, {31'b0, stream_done});
      check_val("flr_done", {31'b0, flr_m}, {31'b0, flr_done});
      for (int ch = 0; ch < `DDR_CHANNELS; ch++) begin
        exp_req  = owns_m ? engine_view(eng_req[ch]) : host_req[ch];
        exp_host = owns_m ? quiet(mem_rsp[ch]) : mem_rsp[ch];
        exp_eng  = owns_m ? mem_rsp[ch] : quiet(mem_rsp[ch]);
        if (owns_m) begin
          exp_host.rresp = '0;
        end
        if (mem_req[ch] !== exp_req) begin
          report_mismatch($sformatf("mem_req[%0d]", ch), $sformatf("%h", exp_req),
                          $sformatf("%h", mem_req[ch]));
        end
        if (host_rsp[ch] !== exp_host) begin
          report_mismatch($sformatf("host_rsp[%0d]", ch), $sformatf("%h", exp_host),
                          $sformatf("%h", host_rsp[ch]));
        end
        if (eng_rsp[ch] !== exp_eng) begin
          report_mismatch($sformatf("eng_rsp[%0d]", ch), $sformatf("%h", exp_eng),
                          $sformatf("%h", eng_rsp[ch]));
        end
      end
    end
  end

endmodule

//--- sim/dram_stream_cl_tb.sv
`timescale 1ns/1ps
`include "dram_stream_cl_defs.svh"

module dram_stream_cl_tb;

  localparam int WAIT_LIMIT = 40;

  logic                        clk;
  logic                        sync_rst_n;
  logic [31:0]                 ctl0;
  logic [`DDR_CHANNELS-1:0]    ddr_ready;
  dram_stream_pkg::scrb_stat_t scrb_stat [`DDR_CHANNELS];
  logic                        flr_assert;
  logic                        stream_start;
  logic                        engine_finished;
  dram_stream_pkg::ddr_req_t   host_req [`DDR_CHANNELS];
  dram_stream_pkg::ddr_req_t   eng_req  [`DDR_CHANNELS];
  dram_stream_pkg::ddr_rsp_t   mem_rsp  [`DDR_CHANNELS];
  logic [`DDR_CHANNELS-1:0]    scrb_enable;
  logic [31:0]                 status0;
  logic [31:0]                 status1;
  logic [31:0]                 id0;
  logic [31:0]                 id1;
  logic                        flr_done;
  logic                        engine_reset;
  logic                        stream_done;
  dram_stream_pkg::ddr_rsp_t   host_rsp [`DDR_CHANNELS];
  dram_stream_pkg::ddr_rsp_t   eng_rsp  [`DDR_CHANNELS];
  dram_stream_pkg::ddr_req_t   mem_req  [`DDR_CHANNELS];

  integer seed;
  bit     aborted;

  dram_stream_cl uut (.*);

  dram_stream_cl_checker chk (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // Random channel payloads
  // --------------------------------------------------
  function automatic dram_stream_pkg::ddr_req_t rand_req();
    logic [1279:0] v;
    for (int i = 0; i < 40; i++) begin
      v[32*i +: 32] = $random(seed);
    end
    return v[$bits(dram_stream_pkg::ddr_req_t)-1:0];
  endfunction

  function automatic dram_stream_pkg::ddr_rsp_t rand_rsp();
    logic [1279:0] v;
    for (int i = 0; i < 40; i++) begin
      v[32*i +: 32] = $random(seed);
    end
    return v[$bits(dram_stream_pkg::ddr_rsp_t)-1:0];
  endfunction

  task automatic drive_traffic(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
      for (int ch = 0; ch < `DDR_CHANNELS; ch++) begin
        host_req[ch] <= rand_req();
        eng_req[ch]  <= rand_req();
        mem_rsp[ch]  <= rand_rsp();
      end
    end
  endtask

  // Polls engine_reset or stream_done at falling edges
  task automatic wait_flag(input string what, input bit use_done, input logic lvl,
                           output int cycles);
    bit seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      if ((use_done ? stream_done : engine_reset) === lvl) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!seen) begin
      $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
      aborted = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // Register steps from the golden file
  // --------------------------------------------------
  task automatic run_golden();
    int          fd;
    int          cnt;
    int          steps;
    string       line;
    string       name;
    logic [31:0] g_ctl;
    logic [3:0]  g_rdy;
    logic [15:0] g_st;
    logic [3:0]  g_dn;
    logic [63:0] g_ab;
    logic [3:0]  g_en;
    logic [31:0] g_st0;
    logic [31:0] g_id0;
    logic [31:0] g_id1;
    steps = 0;
    fd = $fopen("sim/dram_stream_cl_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file sim/dram_stream_cl_golden.txt");
      aborted = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      cnt  = $fgets(line, fd);
      if (cnt > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name, g_ctl, g_rdy, g_st,
                      g_dn, g_ab, g_en, g_st0, g_id0, g_id1);
        if (cnt == 10) begin
          steps++;
          chk.begin_test(name);
          @(posedge clk);
          ctl0      <= g_ctl;
          ddr_ready <= g_rdy;
          for (int i = 0; i < `DDR_CHANNELS; i++) begin
            scrb_stat[i].state <= g_st[4*i +: 3];
            scrb_stat[i].done  <= g_dn[i];
            scrb_stat[i].addr  <= g_ab + 64'(i) * 64'h0000_0010_0000_0001;
          end
          // Control word needs two edges to reach the status registers
          repeat (2) @(posedge clk);
          @(negedge clk);
          chk.expect_regs(g_en, g_st0, g_id0, g_id1);
          chk.end_test();
        end else begin
          $display("A line of the golden file could not be parsed: %s", line);
          aborted = 1'b1;
        end
      end
    end
    $fclose(fd);
    if (steps == 0) begin
      $display("The golden file held no test steps");
      aborted = 1'b1;
    end
  endtask

  task automatic flr_tests();
    int highs;
    int first;
    chk.begin_test("flr_pulse");
    @(posedge clk);
    flr_assert <= 1'b1;
    @(posedge clk);
    flr_assert <= 1'b0;
    highs = 0;
    first = -1;
    for (int k = 0; k < 6; k++) begin
      @(negedge clk);
      if (flr_done) begin
        highs++;
        if (first < 0) first = k;
      end
    end
    chk.check_val("flr_done cycles", 32'd1, 32'(highs));
    chk.check_val("flr_done delay", 32'd2, 32'(first + 1));
    chk.end_test();

    chk.begin_test("flr_held");
    @(posedge clk);
    flr_assert <= 1'b1;
    highs = 0;
    for (int k = 0; k < 8; k++) begin
      @(negedge clk);
      if (flr_done) highs++;
    end
    // Toggles every cycle once the held request is registered
    chk.check_val("flr_done toggles", 32'd3, 32'(highs));
    @(posedge clk);
    flr_assert <= 1'b0;
    repeat (3) @(posedge clk);
    chk.end_test();
  endtask

  // --------------------------------------------------
  // Handover to the streaming engine and back
  // --------------------------------------------------
  task automatic stream_grant();
    int n;
    chk.begin_test("stream_grant");
    @(posedge clk);
    stream_start <= 1'b1;
    wait_flag("engine_reset rise", 1'b0, 1'b1, n);
    if (aborted) return;
    wait_flag("engine_reset fall", 1'b0, 1'b0, n);
    if (aborted) return;
    chk.check_val("engine_reset cycles", 32'd1, 32'(n + 1));
    @(posedge clk);
    stream_start <= 1'b0;
    drive_traffic(20);
    chk.end_test();
  endtask

  task automatic stream_release();
    int n;
    chk.begin_test("stream_release");
    @(posedge clk);
    engine_finished <= 1'b1;
    stream_start    <= 1'b1;
    wait_flag("stream_done rise", 1'b1, 1'b1, n);
    if (aborted) return;
    @(posedge clk);
    engine_finished <= 1'b0;
    // Start is still high so the engine gets a second reset and grant
    wait_flag("second engine_reset rise", 1'b0, 1'b1, n);
    if (aborted) return;
    wait_flag("second engine_reset fall", 1'b0, 1'b0, n);
    if (aborted) return;
    drive_traffic(4);
    @(posedge clk);
    stream_start    <= 1'b0;
    engine_finished <= 1'b1;
    wait_flag("second stream_done rise", 1'b1, 1'b1, n);
    if (aborted) return;
    @(posedge clk);
    engine_finished <= 1'b0;
    drive_traffic(6);
    chk.end_test();
  endtask

  initial begin
    seed            = 32'h5e0a;
    aborted         = 1'b0;
    sync_rst_n      = 1'b0;
    ctl0            = '0;
    ddr_ready       = '0;
    flr_assert      = 1'b0;
    stream_start    = 1'b0;
    engine_finished = 1'b0;
    for (int ch = 0; ch < `DDR_CHANNELS; ch++) begin
      scrb_stat[ch] = '0;
      host_req[ch]  = '0;
      eng_req[ch]   = '0;
      mem_rsp[ch]   = '0;
    end

    chk.begin_test("reset_values");
    repeat (3) @(posedge clk);
    @(negedge clk);
    chk.expect_idle();
    @(posedge clk);
    sync_rst_n <= 1'b1;
    drive_traffic(6);
    chk.end_test();

    run_golden();
    if (!aborted) flr_tests();
    if (!aborted) stream_grant();
    if (!aborted) stream_release();

    $display("Tests passed %0d, failed %0d, mismatches %0d",
             chk.pass_count, chk.fail_count, chk.total_errs);
    if (aborted || chk.fail_count != 0 || chk.total_errs != 0) begin
      $display("SOME TESTS FAILED");
    end else begin
      $display("ALL TESTS PASSED");
    end
    $finish;
  end

endmodule

//--- sim/dram_stream_cl_golden.txt
# name ctl0 ddr_ready scrub_states(nibble per channel) scrub_done addr_base
# expected: scrb_enable status0 id0 id1 (scrubber i address is base + i * 0000001000000001)
norm_low         00000005 3 1234 5 1234560089abc000 5 a1111f53 5ca11d0e 00000a11
norm_sel_ignored 7000000a c 7654 a 1234560089abc000 a a1111fac 5ca11d0e 00000a11
norm_all_ones    0000000f f 7777 f fedcba0000001000 f a1111fff 5ca11d0e 00000a11
dbg_sel1         90000003 f 7531 6 1234560089abc000 3 75310f6f 89abc001 12345610
dbg_sel2         a000000c 1 0246 9 1234560089abc000 c 02460f91 89abc002 12345620
dbg_sel3         b0000000 0 3333 0 1234560089abc000 0 33330f00 89abc003 12345630
dbg_sel3_alt     b0000005 6 7012 3 fedcba0000001000 5 70120f36 00001003 fedcba30
dbg_sel0         80000001 2 1111 f 1234560089abc000 1 11110ff2 89abc000 12345600
dbg_sel4         c0000002 4 4444 1 1234560089abc000 2 44440f14 89abc000 12345600
dbg_sel5         d0000004 8 5555 2 fedcba0000001000 4 55550f28 00001000 fedcba00
dbg_sel6         e0000008 5 6666 4 1234560089abc000 8 66660f45 89abc000 12345600
dbg_sel7         f000000f a 7777 8 fedcba0000001000 f 77770f8a 00001000 fedcba00

//--- dram_stream_cl.f
+incdir+.
rtl/dram_stream_pkg.sv
rtl/host_ctl_regs.sv
rtl/stream_handover.sv
rtl/ddr_chan_mux.sv
rtl/dram_stream_cl.sv
sim/dram_stream_cl_checker.sv
sim/dram_stream_cl_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert
TOP      = dram_stream_cl_tb
FILELIST = dram_stream_cl.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
